//--- src/ctxt_pkg.sv
`default_nettype none

package ctxt_pkg;

    // ==============================
    // widths
    // ==============================
    localparam int ADDR_WIDTH = 16;   // return and context address
    localparam int DATA_WIDTH = 16;   // bit counter and mask
    localparam int PASS_WIDTH = 3;
    localparam int CF_WIDTH   = 128;  // the C/F register
    localparam int LANE_WIDTH = 16;
    localparam int NUM_LANES  = 13;

    // 199 bits of fields, so 9 bits of padding fill the 208-bit word
    localparam int PAD_WIDTH  = NUM_LANES * LANE_WIDTH
                              - 2 * ADDR_WIDTH - 2 * DATA_WIDTH
                              - PASS_WIDTH - CF_WIDTH - 4;

    // ==============================
    // context word
    // ==============================
    typedef struct packed {
        logic [PAD_WIDTH-1:0]  pad;
        logic [ADDR_WIDTH-1:0] ret_addr;
        logic [ADDR_WIDTH-1:0] ctxt_addr;
        logic [DATA_WIDTH-1:0] bit_cnt;
        logic [PASS_WIDTH-1:0] pass;
        logic [DATA_WIDTH-1:0] mask;
        logic [CF_WIDTH-1:0]   c_f;
        logic                  key_a;
        logic                  key_b;
        logic                  key_c;
        logic                  key_f;
    } ctxt_fields_t;

    // fields view for the processor side, lane view for the stack memory
    typedef union packed {
        ctxt_fields_t                          fields;
        logic [NUM_LANES-1:0][LANE_WIDTH-1:0]  lanes;
    } ctxt_word_u;

endpackage

`default_nettype wire

//--- src/stack_bus_if.sv
`timescale 1ns/10ps
`default_nettype none

interface stack_bus_if
#(
    parameter int STACK_DEPTH = 8
);
    import ctxt_pkg::*;

    localparam int PTR_WIDTH = (STACK_DEPTH > 1) ? $clog2(STACK_DEPTH) : 1;

    logic                 push;     // write wr_word at ptr
    logic                 pop;      // register the entry at ptr
    logic [PTR_WIDTH-1:0] ptr;
    ctxt_word_u           wr_word;

    modport ctrl
    (
        output push,
        output pop,
        output ptr,
        output wr_word
    );

    modport lane
    (
        input  push,
        input  pop,
        input  ptr,
        input  wr_word
    );

endinterface

`default_nettype wire

//--- src/int_event_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module int_event_ctrl
#(
    parameter int STACK_DEPTH = 8
)
(
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 int_set,
    input  wire                                 ret_valid,
    input  ctxt_pkg::ctxt_word_u                wr_word,
    stack_bus_if.ctrl                           bus,
    output logic                                rd_valid,
    output logic [$clog2(STACK_DEPTH+1)-1:0]    level,
    output logic                                stack_err
);
    import ctxt_pkg::*;

    localparam int LVL_WIDTH = $clog2(STACK_DEPTH + 1);
    localparam int PTR_WIDTH = (STACK_DEPTH > 1) ? $clog2(STACK_DEPTH) : 1;

    logic                 int_q;
    logic                 ret_q;
    logic                 int_rise;
    logic                 ret_rise;
    logic [LVL_WIDTH-1:0] lvl_next;
    logic [LVL_WIDTH-1:0] lvl_dec;
    logic                 full;
    logic                 empty;
    logic                 do_push;
    logic                 do_pop;

    // ==============================
    // strobe edges and priority
    // ==============================
    assign int_rise = int_set & ~int_q;
    assign ret_rise = ret_valid & ~ret_q;

    // level as it stands after this edge, so a strobe still in flight is counted
    always_comb
    begin
        lvl_next = level;
        if (bus.push)
        begin
            lvl_next = level + 1'b1;
        end
        else if (bus.pop)
        begin
            lvl_next = level - 1'b1;
        end
    end

    assign lvl_dec = lvl_next - 1'b1;
    assign full    = (lvl_next == LVL_WIDTH'(STACK_DEPTH));
    assign empty   = (lvl_next == '0);

    assign do_push = int_rise & ~full;
    assign do_pop  = ret_rise & ~int_rise & ~empty;  // interrupt wins over return

    // ==============================
    // pointer, level and error
    // ==============================
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            int_q     <= 1'b0;
            ret_q     <= 1'b0;
            bus.push  <= 1'b0;
            bus.pop   <= 1'b0;
            bus.ptr   <= '0;
            rd_valid  <= 1'b0;
            level     <= '0;
            stack_err <= 1'b0;
        end
        else
        begin
            int_q    <= int_set;
            ret_q    <= ret_valid;
            bus.push <= do_push;
            bus.pop  <= do_pop;
            rd_valid <= bus.pop;  // lanes hold the popped entry one cycle after pop
            level    <= lvl_next;
            if (do_push)
            begin
                bus.ptr <= lvl_next[PTR_WIDTH-1:0];
            end
            else if (do_pop)
            begin
                bus.ptr <= lvl_dec[PTR_WIDTH-1:0];
            end
            // sticky until reset
            if ((int_rise && full) || (ret_rise && !int_rise && empty))
            begin
                stack_err <= 1'b1;
            end
        end
    end

    // the context is captured at the same edge that sees the interrupt rise
    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            bus.wr_word <= wr_word;
        end
    end

endmodule

`default_nettype wire

//--- src/ctxt_stack_lane.sv
`timescale 1ns/10ps
`default_nettype none

module ctxt_stack_lane
#(
    parameter int STACK_DEPTH = 8,
    parameter int LANE_IDX    = 0
)
(
    input  wire                               clk,
    input  wire                               rst,
    stack_bus_if.lane                         bus,
    output logic [ctxt_pkg::LANE_WIDTH-1:0]   rd_data
);
    import ctxt_pkg::*;

    // this lane's slice of every stack entry
    logic [LANE_WIDTH-1:0] mem [STACK_DEPTH];
    logic [LANE_WIDTH-1:0] wr_slice;

    assign wr_slice = bus.wr_word.lanes[LANE_IDX];

    always_ff @(posedge clk)
    begin
        if (bus.push)
        begin
            mem[bus.ptr] <= wr_slice;
        end
    end

    // ==============================
    // read port
    // ==============================
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            rd_data <= '0;
        end
        else if (bus.pop)
        begin
            rd_data <= mem[bus.ptr];  // ptr already points at the newest entry
        end
    end

endmodule

`default_nettype wire

//--- src/ctxt_restore.sv
`timescale 1ns/10ps
`default_nettype none

module ctxt_restore
(
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 rd_valid,
    input  ctxt_pkg::ctxt_word_u                rd_word,
    output logic                                ctxt_rdy,
    output logic [ctxt_pkg::ADDR_WIDTH-1:0]     ret_addr_ret,
    output logic [ctxt_pkg::ADDR_WIDTH-1:0]     ctxt_addr_ret,
    output logic [ctxt_pkg::DATA_WIDTH-1:0]     tmp_bit_cnt_ret,
    output logic [ctxt_pkg::PASS_WIDTH-1:0]     tmp_pass_ret,
    output logic [ctxt_pkg::DATA_WIDTH-1:0]     tmp_mask_ret,
    output logic [ctxt_pkg::CF_WIDTH-1:0]       tmp_c_f_ret,
    output logic                                tmp_key_a_ret,
    output logic                                tmp_key_b_ret,
    output logic                                tmp_key_c_ret,
    output logic                                tmp_key_f_ret
);
    import ctxt_pkg::*;

    ctxt_fields_t fld;

    assign fld = rd_word.fields;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            ctxt_rdy        <= 1'b0;
            ret_addr_ret    <= '0;
            ctxt_addr_ret   <= '0;
            tmp_bit_cnt_ret <= '0;
            tmp_pass_ret    <= '0;
            tmp_mask_ret    <= '0;
            tmp_c_f_ret     <= '0;
            tmp_key_a_ret   <= 1'b0;
            tmp_key_b_ret   <= 1'b0;
            tmp_key_c_ret   <= 1'b0;
            tmp_key_f_ret   <= 1'b0;
        end
        else
        begin
            ctxt_rdy <= rd_valid;  // rd_valid lasts one cycle and so does ctxt_rdy
            if (rd_valid)
            begin
                ret_addr_ret    <= fld.ret_addr;
                ctxt_addr_ret   <= fld.ctxt_addr;
                tmp_bit_cnt_ret <= fld.bit_cnt;
                tmp_pass_ret    <= fld.pass;
                tmp_mask_ret    <= fld.mask;
                tmp_c_f_ret     <= fld.c_f;
                tmp_key_a_ret   <= fld.key_a;
                tmp_key_b_ret   <= fld.key_b;
                tmp_key_c_ret   <= fld.key_c;
                tmp_key_f_ret   <= fld.key_f;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/int_ctxt_stack.sv
`timescale 1ns/10ps
`default_nettype none

module int_ctxt_stack
#(
    parameter int STACK_DEPTH = 8
)
(
    input  wire                                 clk,
    input  wire                                 rst,

    // processor side, save
    input  wire                                 int_set,
    input  wire                                 ret_valid,
    input  wire [ctxt_pkg::ADDR_WIDTH-1:0]      ret_addr,
    input  wire [ctxt_pkg::ADDR_WIDTH-1:0]      ctxt_addr,
    input  wire [ctxt_pkg::DATA_WIDTH-1:0]      tmp_bit_cnt,
    input  wire [ctxt_pkg::PASS_WIDTH-1:0]      tmp_pass,
    input  wire [ctxt_pkg::DATA_WIDTH-1:0]      tmp_mask,
    input  wire [ctxt_pkg::CF_WIDTH-1:0]        tmp_c_f,
    input  wire                                 tmp_key_a,
    input  wire                                 tmp_key_b,
    input  wire                                 tmp_key_c,
    input  wire                                 tmp_key_f,

    // processor side, restore
    output wire                                 ctxt_rdy,
    output wire [ctxt_pkg::ADDR_WIDTH-1:0]      ret_addr_ret,
    output wire [ctxt_pkg::ADDR_WIDTH-1:0]      ctxt_addr_ret,
    output wire [ctxt_pkg::DATA_WIDTH-1:0]      tmp_bit_cnt_ret,
    output wire [ctxt_pkg::PASS_WIDTH-1:0]      tmp_pass_ret,
    output wire [ctxt_pkg::DATA_WIDTH-1:0]      tmp_mask_ret,
    output wire [ctxt_pkg::CF_WIDTH-1:0]        tmp_c_f_ret,
    output wire                                 tmp_key_a_ret,
    output wire                                 tmp_key_b_ret,
    output wire                                 tmp_key_c_ret,
    output wire                                 tmp_key_f_ret,

    output wire [$clog2(STACK_DEPTH+1)-1:0]     stack_level,
    output wire                                 stack_err
);
    import ctxt_pkg::*;

    wire ctxt_word_u            wr_word;
    wire ctxt_word_u            rd_word;
    wire [LANE_WIDTH-1:0]       rd_slice [NUM_LANES];
    wire                        rd_valid;

    stack_bus_if #(.STACK_DEPTH(STACK_DEPTH)) bus ();

    // ==============================
    // context word packing
    // ==============================
    assign wr_word.fields = '{
        pad:       '0,
        ret_addr:  ret_addr,
        ctxt_addr: ctxt_addr,
        bit_cnt:   tmp_bit_cnt,
        pass:      tmp_pass,
        mask:      tmp_mask,
        c_f:       tmp_c_f,
        key_a:     tmp_key_a,
        key_b:     tmp_key_b,
        key_c:     tmp_key_c,
        key_f:     tmp_key_f
    };

    int_event_ctrl #(.STACK_DEPTH(STACK_DEPTH)) u_ctrl
    (
        .clk       (clk),
        .rst       (rst),
        .int_set   (int_set),
        .ret_valid (ret_valid),
        .wr_word   (wr_word),
        .bus       (bus.ctrl),
        .rd_valid  (rd_valid),
        .level     (stack_level),
        .stack_err (stack_err)
    );

    // ==============================
    // stack lanes
    // ==============================
    genvar g;
    generate
        for (g = 0; g < NUM_LANES; g = g + 1)
        begin : g_lane
            ctxt_stack_lane
            #(
                .STACK_DEPTH (STACK_DEPTH),
                .LANE_IDX    (g)
            ) u_lane
            (
                .clk     (clk),
                .rst     (rst),
                .bus     (bus.lane),
                .rd_data (rd_slice[g])
            );

            assign rd_word.lanes[g] = rd_slice[g];  // lane g owns bits [16g+15:16g]
        end
    endgenerate

    ctxt_restore u_restore
    (
        .clk             (clk),
        .rst             (rst),
        .rd_valid        (rd_valid),
        .rd_word         (rd_word),
        .ctxt_rdy        (ctxt_rdy),
        .ret_addr_ret    (ret_addr_ret),
        .ctxt_addr_ret   (ctxt_addr_ret),
        .tmp_bit_cnt_ret (tmp_bit_cnt_ret),
        .tmp_pass_ret    (tmp_pass_ret),
        .tmp_mask_ret    (tmp_mask_ret),
        .tmp_c_f_ret     (tmp_c_f_ret),
        .tmp_key_a_ret   (tmp_key_a_ret),
        .tmp_key_b_ret   (tmp_key_b_ret),
        .tmp_key_c_ret   (tmp_key_c_ret),
        .tmp_key_f_ret   (tmp_key_f_ret)
    );

endmodule

`default_nettype wire

//--- tests/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// each row holds the operation, a context seed that tags the return address
// and the expected stack_err after the row
typedef enum logic [2:0]
{
    OP_IDLE,
    OP_PUSH,
    OP_POP,
    OP_HOLD,    // int_set held high over five edges
    OP_BOTH,    // int_set and ret_valid rise together
    OP_RESET    // reset pulse in the middle of the sequence
} op_t;

typedef struct packed
{
    op_t         op;
    logic [15:0] ctx_seed;
    logic        exp_err;
} vec_t;

localparam int NUM_VECTORS = 30;

localparam vec_t VECTORS [NUM_VECTORS] = '{
    '{OP_PUSH,  16'h1a01, 1'b0},
    '{OP_POP,   16'h0000, 1'b0},
    '{OP_PUSH,  16'h1a02, 1'b0},
    '{OP_PUSH,  16'h1a03, 1'b0},
    '{OP_POP,   16'h0000, 1'b0},
    '{OP_IDLE,  16'h0000, 1'b0},
    '{OP_PUSH,  16'h1a06, 1'b0},
    '{OP_PUSH,  16'h1a07, 1'b0},
    '{OP_PUSH,  16'h1a08, 1'b0},  // stack now full
    '{OP_POP,   16'h0000, 1'b0},
    '{OP_POP,   16'h0000, 1'b0},
    '{OP_POP,   16'h0000, 1'b0},
    '{OP_POP,   16'h0000, 1'b0},
    '{OP_HOLD,  16'h1a0d, 1'b0},
    '{OP_BOTH,  16'h1a0e, 1'b0},
    '{OP_POP,   16'h0000, 1'b0},
    '{OP_POP,   16'h0000, 1'b0},
    '{OP_PUSH,  16'h1a11, 1'b0},
    '{OP_PUSH,  16'h1a12, 1'b0},
    '{OP_PUSH,  16'h1a13, 1'b0},
    '{OP_PUSH,  16'h1a14, 1'b0},
    '{OP_PUSH,  16'h1a15, 1'b1},  // push at full
    '{OP_POP,   16'h0000, 1'b1},
    '{OP_POP,   16'h0000, 1'b1},
    '{OP_POP,   16'h0000, 1'b1},
    '{OP_POP,   16'h0000, 1'b1},
    '{OP_RESET, 16'h0000, 1'b0},  // clears the sticky error
    '{OP_POP,   16'h0000, 1'b1},  // pop at empty
    '{OP_PUSH,  16'h1a1c, 1'b1},
    '{OP_POP,   16'h0000, 1'b1}
};

`endif

//--- tests/int_ctxt_stack_tb.sv
`timescale 1ns/10ps
`default_nettype none

module int_ctxt_stack_tb;
    import ctxt_pkg::*;

    localparam int TB_DEPTH   = 4;
    localparam int LVL_W      = $clog2(TB_DEPTH + 1);
    localparam int ROW_CYCLES = 7;   // strobe edge plus room for the 3-edge restore latency

    `include "tb_vectors.svh"

    localparam int CYCLE_LIMIT = NUM_VECTORS * 8 + 20;

    logic         clk       = 1'b0;
    logic         rst       = 1'b0;
    logic         int_set   = 1'b0;
    logic         ret_valid = 1'b0;
    ctxt_fields_t drv       = '0;

    wire                  ctxt_rdy;
    wire [ADDR_WIDTH-1:0] ret_addr_ret;
    wire [ADDR_WIDTH-1:0] ctxt_addr_ret;
    wire [DATA_WIDTH-1:0] tmp_bit_cnt_ret;
    wire [PASS_WIDTH-1:0] tmp_pass_ret;
    wire [DATA_WIDTH-1:0] tmp_mask_ret;
    wire [CF_WIDTH-1:0]   tmp_c_f_ret;
    wire                  tmp_key_a_ret;
    wire                  tmp_key_b_ret;
    wire                  tmp_key_c_ret;
    wire                  tmp_key_f_ret;
    wire [LVL_W-1:0]      stack_level;
    wire                  stack_err;

    integer       rnd_seed  = 44530;
    int           cycle_cnt = 0;
    int           cur_row   = -1;
    ctxt_fields_t model_q[$];          // reference LIFO with the newest entry at the back
    ctxt_fields_t exp_ret   = '0;

    int_ctxt_stack #(.STACK_DEPTH(TB_DEPTH)) UUT
    (
        .clk             (clk),
        .rst             (rst),
        .int_set         (int_set),
        .ret_valid       (ret_valid),
        .ret_addr        (drv.ret_addr),
        .ctxt_addr       (drv.ctxt_addr),
        .tmp_bit_cnt     (drv.bit_cnt),
        .tmp_pass        (drv.pass),
        .tmp_mask        (drv.mask),
        .tmp_c_f         (drv.c_f),
        .tmp_key_a       (drv.key_a),
        .tmp_key_b       (drv.key_b),
        .tmp_key_c       (drv.key_c),
        .tmp_key_f       (drv.key_f),
        .ctxt_rdy        (ctxt_rdy),
        .ret_addr_ret    (ret_addr_ret),
        .ctxt_addr_ret   (ctxt_addr_ret),
        .tmp_bit_cnt_ret (tmp_bit_cnt_ret),
        .tmp_pass_ret    (tmp_pass_ret),
        .tmp_mask_ret    (tmp_mask_ret),
        .tmp_c_f_ret     (tmp_c_f_ret),
        .tmp_key_a_ret   (tmp_key_a_ret),
        .tmp_key_b_ret   (tmp_key_b_ret),
        .tmp_key_c_ret   (tmp_key_c_ret),
        .tmp_key_f_ret   (tmp_key_f_ret),
        .stack_level     (stack_level),
        .stack_err       (stack_err)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT)
        begin
            $display("ERROR: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    // ==============================
    // helpers
    // ==============================
    task automatic report_failure(input string what);
        $display("** Error at %0t: %s", $time, what);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        assert (got === exp)
        else
        begin
            report_failure($sformatf("row %0d: %s is %0h, expected %0h", cur_row, name, got, exp));
        end
    endtask

    task automatic check_restore();
        check_value("ret_addr_ret", 128'(ret_addr_ret), 128'(exp_ret.ret_addr));
        check_value("ctxt_addr_ret", 128'(ctxt_addr_ret), 128'(exp_ret.ctxt_addr));
        check_value("tmp_bit_cnt_ret", 128'(tmp_bit_cnt_ret), 128'(exp_ret.bit_cnt));
        check_value("tmp_pass_ret", 128'(tmp_pass_ret), 128'(exp_ret.pass));
        check_value("tmp_mask_ret", 128'(tmp_mask_ret), 128'(exp_ret.mask));
        check_value("tmp_c_f_ret", tmp_c_f_ret, exp_ret.c_f);
        check_value("tmp_key_a_ret", 128'(tmp_key_a_ret), 128'(exp_ret.key_a));
        check_value("tmp_key_b_ret", 128'(tmp_key_b_ret), 128'(exp_ret.key_b));
        check_value("tmp_key_c_ret", 128'(tmp_key_c_ret), 128'(exp_ret.key_c));
        check_value("tmp_key_f_ret", 128'(tmp_key_f_ret), 128'(exp_ret.key_f));
    endtask

    // reset empties the stack and clears every output
    task automatic check_reset_state();
        model_q.delete();
        exp_ret = '0;
        check_value("ctxt_rdy", 128'(ctxt_rdy), 128'(0));
        check_value("stack_err", 128'(stack_err), 128'(0));
        check_value("stack_level", 128'(stack_level), 128'(0));
        check_restore();
    endtask

    task automatic pulse_reset();
        @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        check_reset_state();
    endtask

    // the row seed tags the return address and the other fields are random
    task automatic build_context(input logic [15:0] tag, output ctxt_fields_t ctx);
        ctx           = '0;
        ctx.ret_addr  = tag;
        ctx.ctxt_addr = 16'($random(rnd_seed));
        ctx.bit_cnt   = 16'($random(rnd_seed));
        ctx.pass      = 3'($random(rnd_seed));
        ctx.mask      = 16'($random(rnd_seed));
        ctx.c_f       = {$random(rnd_seed), $random(rnd_seed), $random(rnd_seed),
                         $random(rnd_seed)};
        {ctx.key_a, ctx.key_b, ctx.key_c, ctx.key_f} = 4'($random(rnd_seed));
    endtask

    task automatic run_row(input vec_t row);
        ctxt_fields_t ctx;
        logic         is_push;
        logic         valid_pop;
        int           release_at;
        build_context(row.ctx_seed, ctx);
        is_push    = (row.op == OP_PUSH) || (row.op == OP_HOLD) || (row.op == OP_BOTH);
        release_at = (row.op == OP_HOLD) ? 5 : 1;
        valid_pop  = 1'b0;
        if (is_push)
        begin
            if (model_q.size() < TB_DEPTH)
            begin
                model_q.push_back(ctx);
            end
        end
        else if ((row.op == OP_POP) && (model_q.size() > 0))
        begin
            exp_ret   = model_q.pop_back();
            valid_pop = 1'b1;
        end

        @(posedge clk);
        drv       <= ctx;
        int_set   <= is_push;
        ret_valid <= (row.op == OP_POP) || (row.op == OP_BOTH);
        for (int k = 0; k < ROW_CYCLES; k++)
        begin
            if (k > 0)
            begin
                @(posedge clk);
                if (k == release_at)
                begin
                    int_set   <= 1'b0;
                    ret_valid <= 1'b0;
                end
            end
            @(negedge clk);
            check_value("ctxt_rdy", 128'(ctxt_rdy), 128'(valid_pop && (k == 3)));
        end

        check_value("stack_level", 128'(stack_level), 128'(model_q.size()));
        check_value("stack_err", 128'(stack_err), 128'(row.exp_err));
        check_restore();
    endtask

    // ==============================
    // test sequence
    // ==============================
    initial
    begin
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        check_reset_state();

        for (int r = 0; r < NUM_VECTORS; r++)
        begin
            cur_row = r;
            if (VECTORS[r].op == OP_RESET)
            begin
                pulse_reset();
            end
            else
            begin
                run_row(VECTORS[r]);
            end
        end

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+tests
src/ctxt_pkg.sv
src/stack_bus_if.sv
src/int_event_ctrl.sv
src/ctxt_stack_lane.sv
src/ctxt_restore.sv
src/int_ctxt_stack.sv
tests/int_ctxt_stack_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it, the exit status carries the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module int_ctxt_stack_tb \
    -Mdir obj_dir \
    -f sim.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit $build_status
fi

./obj_dir/Vint_ctxt_stack_tb
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "simulation ended with status $sim_status"
    exit $sim_status
fi

echo "simulation finished cleanly"
exit 0
